// ==== rtl/snow64_alu_pkg.sv ====
package snow64_alu_pkg;

	// operand word and host bus widths
	localparam int DATA_WIDTH = 64;
	localparam int APB_DATA_WIDTH = 32;
	localparam int APB_ADDR_WIDTH = 5;

	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;
	typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;

	// operation codes, 10 to 15 are rejected by the register file
	typedef enum logic [3:0]
	{
		op_add = 4'd0,
		op_sub = 4'd1,
		op_sltu = 4'd2,
		op_slts = 4'd3,
		op_and = 4'd4,
		op_or = 4'd5,
		op_xor = 4'd6,
		op_lsl = 4'd7,
		op_lsr = 4'd8,
		op_asr = 4'd9
	} alu_op_e;

	// lane size, value n means 8 << n bits per lane
	typedef enum logic [1:0]
	{
		lane_8 = 2'd0,
		lane_16 = 2'd1,
		lane_32 = 2'd2,
		lane_64 = 2'd3
	} lane_width_e;

	typedef enum logic [1:0]
	{
		shift_lsl = 2'd0,
		shift_lsr = 2'd1,
		shift_asr = 2'd2
	} shift_kind_e;

	// host to completer
	typedef struct packed
	{
		logic psel;
		logic penable;
		logic pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	// completer to host
	typedef struct packed
	{
		logic pready;
		logic pslverr;
		apb_data_t prdata;
	} apb_rsp_t;

	// one command for the execution stage
	typedef struct packed
	{
		alu_op_e op;
		lane_width_e width;
		data_t a;
		data_t b;
	} alu_cmd_t;

	// register map, byte offsets
	localparam apb_addr_t addr_a_lo = 5'h00;
	localparam apb_addr_t addr_a_hi = 5'h04;
	localparam apb_addr_t addr_b_lo = 5'h08;
	localparam apb_addr_t addr_b_hi = 5'h0C;
	localparam apb_addr_t addr_ctrl = 5'h10;
	localparam apb_addr_t addr_res_lo = 5'h14;
	localparam apb_addr_t addr_res_hi = 5'h18;
	localparam apb_addr_t addr_status = 5'h1C;

endpackage

// ==== rtl/snow64_lane_shifter.sv ====
`timescale 1ns/1ps

module snow64_lane_shifter
#(
	parameter int LANE_WIDTH = 64
)
(
	input snow64_alu_pkg::data_t to_shift,
	input snow64_alu_pkg::data_t amount,
	input snow64_alu_pkg::shift_kind_e kind,
	output snow64_alu_pkg::data_t shifted
);

	localparam int NUM_LANES = snow64_alu_pkg::DATA_WIDTH / LANE_WIDTH;
	localparam int NUM_STAGES = $clog2(LANE_WIDTH);

	typedef logic [LANE_WIDTH-1:0] lane_t;

	logic is_left;
	logic is_arith;

	// both right shifts share one path, only the fill bit differs
	assign is_left = (kind == snow64_alu_pkg::shift_lsl);
	assign is_arith = (kind == snow64_alu_pkg::shift_asr);

	for (genvar l = 0; l < NUM_LANES; l++)
	begin : g_lane
		lane_t lane_in;
		lane_t lane_amount;
		lane_t stage [NUM_STAGES+1];
		logic fill;
		logic over_range;

		assign lane_in = to_shift[l*LANE_WIDTH +: LANE_WIDTH];

		// amount comes from the same lane of b
		assign lane_amount = amount[l*LANE_WIDTH +: LANE_WIDTH];

		// sign of the original lane, for asr only
		assign fill = is_arith & lane_in[LANE_WIDTH-1];

		// any bit at or above log2 of the width
		assign over_range = |lane_amount[LANE_WIDTH-1:NUM_STAGES];

		assign stage[0] = lane_in;

		// stage s moves by 2**s when amount bit s is set
		for (genvar s = 0; s < NUM_STAGES; s++)
		begin : g_stage
			localparam int STEP = 1 << s;

			lane_t left;
			lane_t right;

			assign left = {stage[s][LANE_WIDTH-1-STEP:0], {STEP{1'b0}}};
			assign right = {{STEP{fill}}, stage[s][LANE_WIDTH-1:STEP]};

			always_comb
			begin
				if (!lane_amount[s])
				begin
					stage[s+1] = stage[s];
				end
				else if (is_left)
				begin
					stage[s+1] = left;
				end
				else
				begin
					stage[s+1] = right;
				end
			end
		end

		// too far, all bits fall out: zero, or sign fill for asr
		assign shifted[l*LANE_WIDTH +: LANE_WIDTH] = over_range
			? {LANE_WIDTH{fill}}
			: stage[NUM_STAGES];
	end

endmodule

// ==== rtl/snow64_lane_adder.sv ====
`timescale 1ns/1ps

module snow64_lane_adder
(
	input snow64_alu_pkg::data_t a,
	input snow64_alu_pkg::data_t b,
	input snow64_alu_pkg::lane_width_e width,
	input snow64_alu_pkg::alu_op_e op,
	output snow64_alu_pkg::data_t sum
);

	localparam int NUM_BYTES = snow64_alu_pkg::DATA_WIDTH / 8;

	logic sub;
	snow64_alu_pkg::data_t b_eff;
	snow64_alu_pkg::data_t diff;
	logic [NUM_BYTES-1:0] carry_out;

	// sub and both compares are a + ~b + 1
	assign sub = (op != snow64_alu_pkg::op_add);
	assign b_eff = sub ? ~b : b;

	// byte-wise ripple, carry reloaded at each lane start
	always_comb
	begin
		int lane_bytes;
		logic carry;
		logic [8:0] byte_sum;

		lane_bytes = 1 << int'(width);
		carry = 1'b0;
		for (int i = 0; i < NUM_BYTES; i++)
		begin
			if ((i % lane_bytes) == 0)
			begin
				carry = sub;
			end
			byte_sum = {1'b0, a[i*8 +: 8]} + {1'b0, b_eff[i*8 +: 8]} + {8'd0, carry};
			diff[i*8 +: 8] = byte_sum[7:0];
			carry = byte_sum[8];
			carry_out[i] = carry;
		end
	end

	// compare results land in bit 0 of each lane
	always_comb
	begin
		int lane_bytes;
		int top_byte;
		int msb;
		logic a_msb;
		logic b_msb;
		logic d_msb;
		logic lt;

		lane_bytes = 1 << int'(width);
		sum = diff;
		for (int i = 0; i < NUM_BYTES; i++)
		begin
			// top byte of the lane that holds byte i
			top_byte = i | (lane_bytes - 1);
			msb = top_byte * 8 + 7;
			a_msb = a[msb];
			b_msb = b[msb];
			d_msb = diff[msb];

			// unsigned: borrow out of the lane
			// signed: n xor v of the lane difference
			if (op == snow64_alu_pkg::op_sltu)
			begin
				lt = ~carry_out[top_byte];
			end
			else
			begin
				lt = d_msb ^ ((a_msb ^ b_msb) & (a_msb ^ d_msb));
			end

			if (op == snow64_alu_pkg::op_sltu || op == snow64_alu_pkg::op_slts)
			begin
				sum[i*8 +: 8] = ((i % lane_bytes) == 0) ? {7'd0, lt} : 8'd0;
			end
		end
	end

endmodule

// ==== rtl/snow64_alu_exec.sv ====
`timescale 1ns/1ps

module snow64_alu_exec
(
	input logic clk,
	input logic arst_n,
	input logic launch,
	input snow64_alu_pkg::alu_cmd_t cmd,
	output snow64_alu_pkg::data_t result,
	output logic result_valid
);

	snow64_alu_pkg::shift_kind_e kind;
	snow64_alu_pkg::data_t shift_out [4];
	snow64_alu_pkg::data_t sum;
	snow64_alu_pkg::data_t next_result;

	// shift ops to shifter mode, lsl also for non-shift ops
	always_comb
	begin
		case (cmd.op)
			snow64_alu_pkg::op_lsr: kind = snow64_alu_pkg::shift_lsr;
			snow64_alu_pkg::op_asr: kind = snow64_alu_pkg::shift_asr;
			default: kind = snow64_alu_pkg::shift_lsl;
		endcase
	end

	// one shifter per lane width, index matches lane_width_e
	for (genvar g = 0; g < 4; g++)
	begin : g_shift
		snow64_lane_shifter
		#(
			.LANE_WIDTH(8 << g)
		)
		snow64_lane_shifter_i
		(
			.to_shift(cmd.a),
			.amount(cmd.b),
			.kind(kind),
			.shifted(shift_out[g])
		);
	end

	snow64_lane_adder snow64_lane_adder_i
	(
		.a(cmd.a),
		.b(cmd.b),
		.width(cmd.width),
		.op(cmd.op),
		.sum(sum)
	);

	// bitwise ops ignore the lane width
	always_comb
	begin
		case (cmd.op)
			snow64_alu_pkg::op_add,
			snow64_alu_pkg::op_sub,
			snow64_alu_pkg::op_sltu,
			snow64_alu_pkg::op_slts: next_result = sum;
			snow64_alu_pkg::op_and: next_result = cmd.a & cmd.b;
			snow64_alu_pkg::op_or: next_result = cmd.a | cmd.b;
			snow64_alu_pkg::op_xor: next_result = cmd.a ^ cmd.b;
			snow64_alu_pkg::op_lsl,
			snow64_alu_pkg::op_lsr,
			snow64_alu_pkg::op_asr: next_result = shift_out[cmd.width];
			default: next_result = '0;
		endcase
	end

	// single register stage, accepts a launch every cycle
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			result <= '0;
			result_valid <= 1'b0;
		end
		else
		begin
			result_valid <= launch;
			if (launch)
			begin
				result <= next_result;
			end
		end
	end

endmodule

// ==== rtl/snow64_alu_apb_regs.sv ====
`timescale 1ns/1ps

module snow64_alu_apb_regs
(
	input logic clk,
	input logic arst_n,
	input snow64_alu_pkg::apb_req_t req,
	output snow64_alu_pkg::apb_rsp_t rsp,
	output logic launch,
	output snow64_alu_pkg::alu_cmd_t cmd,
	input snow64_alu_pkg::data_t result,
	input logic result_valid
);

	snow64_alu_pkg::data_t a_q;
	snow64_alu_pkg::data_t b_q;
	snow64_alu_pkg::data_t res_q;
	snow64_alu_pkg::alu_cmd_t cmd_q;
	logic launch_q;
	logic pending_q;
	logic done_q;

	logic access;
	logic mapped;
	logic res_sel;
	logic ctrl_sel;
	logic op_legal;
	logic stall;
	logic xfer;
	logic err;
	logic wr_ok;
	logic ctrl_wr;
	logic retire;
	snow64_alu_pkg::apb_data_t rdata;

	assign access = req.psel & req.penable;

	// address decode and read mux
	always_comb
	begin
		mapped = 1'b1;
		res_sel = 1'b0;
		rdata = '0;
		case (req.paddr)
			snow64_alu_pkg::addr_a_lo: rdata = a_q[31:0];
			snow64_alu_pkg::addr_a_hi: rdata = a_q[63:32];
			snow64_alu_pkg::addr_b_lo: rdata = b_q[31:0];
			snow64_alu_pkg::addr_b_hi: rdata = b_q[63:32];
			snow64_alu_pkg::addr_ctrl: rdata = {26'd0, cmd_q.width, cmd_q.op};
			snow64_alu_pkg::addr_res_lo:
			begin
				rdata = res_q[31:0];
				res_sel = 1'b1;
			end
			snow64_alu_pkg::addr_res_hi:
			begin
				rdata = res_q[63:32];
				res_sel = 1'b1;
			end
			snow64_alu_pkg::addr_status:
			begin
				rdata = {31'd0, done_q};
				res_sel = 1'b1;
			end
			default: mapped = 1'b0;
		endcase
	end

	assign ctrl_sel = (req.paddr == snow64_alu_pkg::addr_ctrl);
	assign op_legal = (req.pwdata[3:0] <= snow64_alu_pkg::op_asr);

	// result side reads wait for the in-flight operation
	assign stall = access & ~req.pwrite & res_sel & pending_q;
	assign xfer = access & ~stall;

	// read-only write, hole in the map, bad op code
	assign err = ~mapped
		| (req.pwrite & res_sel)
		| (req.pwrite & ctrl_sel & ~op_legal);

	assign wr_ok = xfer & req.pwrite & ~err;
	assign ctrl_wr = wr_ok & ctrl_sel;

	// a result with a newer launch behind it is not the last one
	assign retire = result_valid & ~launch_q;

	assign rsp = '{
		pready: xfer,
		pslverr: xfer & err,
		prdata: (xfer & ~req.pwrite) ? rdata : '0
	};

	assign launch = launch_q;
	assign cmd = cmd_q;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			a_q <= '0;
			b_q <= '0;
			res_q <= '0;
			cmd_q <= '0;
			launch_q <= 1'b0;
			pending_q <= 1'b0;
			done_q <= 1'b0;
		end
		else
		begin
			// operand halves
			if (wr_ok)
			begin
				case (req.paddr)
					snow64_alu_pkg::addr_a_lo: a_q[31:0] <= req.pwdata;
					snow64_alu_pkg::addr_a_hi: a_q[63:32] <= req.pwdata;
					snow64_alu_pkg::addr_b_lo: b_q[31:0] <= req.pwdata;
					snow64_alu_pkg::addr_b_hi: b_q[63:32] <= req.pwdata;
					default: ;
				endcase
			end

			// snapshot operands so later a/b writes leave the command alone
			launch_q <= ctrl_wr;
			if (ctrl_wr)
			begin
				cmd_q.op <= snow64_alu_pkg::alu_op_e'(req.pwdata[3:0]);
				cmd_q.width <= snow64_alu_pkg::lane_width_e'(req.pwdata[5:4]);
				cmd_q.a <= a_q;
				cmd_q.b <= b_q;
			end

			// every result is stored, the newest arrives last
			if (result_valid)
			begin
				res_q <= result;
			end

			if (ctrl_wr)
			begin
				pending_q <= 1'b1;
				done_q <= 1'b0;
			end
			else if (retire)
			begin
				pending_q <= 1'b0;
				done_q <= 1'b1;
			end
		end
	end

endmodule

// ==== rtl/snow64_alu_top.sv ====
`timescale 1ns/1ps

module snow64_alu_top
(
	input logic clk,
	input logic arst_n,
	input snow64_alu_pkg::apb_req_t apb_req,
	output snow64_alu_pkg::apb_rsp_t apb_rsp
);

	// register file to execution stage
	logic launch;
	snow64_alu_pkg::alu_cmd_t cmd;

	// execution stage back to register file
	snow64_alu_pkg::data_t result;
	logic result_valid;

	snow64_alu_apb_regs snow64_alu_apb_regs_i
	(
		.clk(clk),
		.arst_n(arst_n),
		.req(apb_req),
		.rsp(apb_rsp),
		.launch(launch),
		.cmd(cmd),
		.result(result),
		.result_valid(result_valid)
	);

	snow64_alu_exec snow64_alu_exec_i
	(
		.clk(clk),
		.arst_n(arst_n),
		.launch(launch),
		.cmd(cmd),
		.result(result),
		.result_valid(result_valid)
	);

endmodule

// ==== sim/snow64_alu_properties.sv ====
`timescale 1ns/1ps

module snow64_alu_properties
(
	input logic clk,
	input logic arst_n,
	input snow64_alu_pkg::apb_req_t req,
	input snow64_alu_pkg::apb_rsp_t rsp,
	input logic launch,
	input logic result_valid,
	input logic pending
);

	logic access;
	logic res_read;
	logic ctrl_done;

	assign access = req.psel & req.penable;

	// reads that may stall on an in-flight operation
	assign res_read = ~req.pwrite & (req.paddr == snow64_alu_pkg::addr_res_lo
		|| req.paddr == snow64_alu_pkg::addr_res_hi
		|| req.paddr == snow64_alu_pkg::addr_status);

	// accepted ctrl write with a legal op
	assign ctrl_done = access & rsp.pready & ~rsp.pslverr & req.pwrite
		& (req.paddr == snow64_alu_pkg::addr_ctrl);

	a_slverr_in_access: assert property (@(posedge clk) disable iff (!arst_n)
		rsp.pslverr |-> access && rsp.pready)
		else $error("pslverr outside a completing access phase");

	a_valid_after_launch: assert property (@(posedge clk) disable iff (!arst_n)
		launch |=> result_valid)
		else $error("result_valid missing one cycle after launch");

	a_valid_has_launch: assert property (@(posedge clk) disable iff (!arst_n)
		result_valid |-> $past(launch))
		else $error("result_valid without a launch in the cycle before");

	a_wait_only_on_result: assert property (@(posedge clk) disable iff (!arst_n)
		access && !rsp.pready |-> pending && res_read)
		else $error("wait state outside a pending result read");

	a_launch_from_ctrl: assert property (@(posedge clk) disable iff (!arst_n)
		launch |-> $past(ctrl_done))
		else $error("launch without an accepted ctrl write");

endmodule

bind snow64_alu_apb_regs snow64_alu_properties snow64_alu_properties_i
(
	.clk(clk),
	.arst_n(arst_n),
	.req(req),
	.rsp(rsp),
	.launch(launch),
	.result_valid(result_valid),
	.pending(pending_q)
);

// ==== sim/snow64_alu_tb.sv ====
`timescale 1ns/1ps

module snow64_alu_tb;

	localparam int CLK_PERIOD = 20;
	localparam int SAMPLE_DELAY = 5;
	localparam int NUM_RANDOM = 200;

	// op encoding as the host sees it in ctrl
	localparam logic [3:0] op_add = 4'd0;
	localparam logic [3:0] op_sub = 4'd1;
	localparam logic [3:0] op_sltu = 4'd2;
	localparam logic [3:0] op_slts = 4'd3;
	localparam logic [3:0] op_and = 4'd4;
	localparam logic [3:0] op_or = 4'd5;
	localparam logic [3:0] op_xor = 4'd6;
	localparam logic [3:0] op_lsl = 4'd7;
	localparam logic [3:0] op_lsr = 4'd8;
	localparam logic [3:0] op_asr = 4'd9;

	typedef struct packed
	{
		logic [3:0] op;
		logic [1:0] width;
		snow64_alu_pkg::data_t a;
		snow64_alu_pkg::data_t b;
		snow64_alu_pkg::data_t expected;
	} vector_t;

	logic clk;
	logic arst_n;
	snow64_alu_pkg::apb_req_t apb_req;
	snow64_alu_pkg::apb_rsp_t apb_rsp;

	vector_t vectors [$];
	int unsigned error_count;
	int unsigned cycle_count;
	int unsigned cycle_limit;

	snow64_alu_top snow64_alu_top_i
	(
		.clk(clk),
		.arst_n(arst_n),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	// count cycles up to the limit set from the test length
	initial
	begin
		cycle_count = 0;
		do
		begin
			@(posedge clk);
			cycle_count++;
		end
		while (cycle_count <= cycle_limit);
		$display("timeout after %0d cycles, the DUT stopped completing transfers",
			cycle_count);
		$display("Finished with errors");
		$finish;
	end

	// setup then access until pready
	task automatic apb_transfer(input logic write, input snow64_alu_pkg::apb_addr_t addr,
		input snow64_alu_pkg::apb_data_t wdata, output snow64_alu_pkg::apb_data_t rdata,
		output logic slverr);
		@(negedge clk);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = write;
		apb_req.paddr = addr;
		apb_req.pwdata = wdata;
		@(negedge clk);
		apb_req.penable = 1'b1;
		// sample in the low phase clear of both edges
		#(SAMPLE_DELAY);
		while (!apb_rsp.pready)
		begin
			@(negedge clk);
			#(SAMPLE_DELAY);
		end
		rdata = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		@(posedge clk);
	endtask

	task automatic apb_write(input snow64_alu_pkg::apb_addr_t addr,
		input snow64_alu_pkg::apb_data_t wdata, output logic slverr);
		snow64_alu_pkg::apb_data_t unused;
		apb_transfer(1'b1, addr, wdata, unused, slverr);
	endtask

	task automatic apb_read(input snow64_alu_pkg::apb_addr_t addr,
		output snow64_alu_pkg::apb_data_t rdata, output logic slverr);
		apb_transfer(1'b0, addr, '0, rdata, slverr);
	endtask

	// plain read that must not be refused
	task automatic read_register(input snow64_alu_pkg::apb_addr_t addr,
		output snow64_alu_pkg::apb_data_t rdata);
		logic slverr;
		apb_read(addr, rdata, slverr);
		if (slverr)
		begin
			$display("unexpected pslverr on the read at address 0x%h", addr);
			error_count++;
		end
	endtask

	task automatic check_value(input string name, input snow64_alu_pkg::data_t expected,
		input snow64_alu_pkg::data_t actual);
		if (actual !== expected)
		begin
			$display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, expected,
				actual);
			error_count++;
		end
	endtask

	// access that must be refused with pslverr
	task automatic expect_slverr(input logic write, input snow64_alu_pkg::apb_addr_t addr,
		input snow64_alu_pkg::apb_data_t wdata);
		snow64_alu_pkg::apb_data_t rdata;
		logic slverr;
		apb_transfer(write, addr, wdata, rdata, slverr);
		if (!slverr)
		begin
			$display("no pslverr for the %s at address 0x%h", write ? "write" : "read", addr);
			error_count++;
		end
	endtask

	// load operands, launch, then read back at once
	task automatic run_command(input logic [3:0] op, input logic [1:0] width,
		input snow64_alu_pkg::data_t a, input snow64_alu_pkg::data_t b,
		output snow64_alu_pkg::data_t result);
		logic err;
		logic err_any;
		snow64_alu_pkg::apb_data_t lo;
		snow64_alu_pkg::apb_data_t hi;
		apb_write(snow64_alu_pkg::addr_a_lo, a[31:0], err);
		err_any = err;
		apb_write(snow64_alu_pkg::addr_a_hi, a[63:32], err);
		err_any |= err;
		apb_write(snow64_alu_pkg::addr_b_lo, b[31:0], err);
		err_any |= err;
		apb_write(snow64_alu_pkg::addr_b_hi, b[63:32], err);
		err_any |= err;
		apb_write(snow64_alu_pkg::addr_ctrl, {26'd0, width, op}, err);
		err_any |= err;
		apb_read(snow64_alu_pkg::addr_res_lo, lo, err);
		err_any |= err;
		apb_read(snow64_alu_pkg::addr_res_hi, hi, err);
		err_any |= err;
		if (err_any)
		begin
			$display("unexpected pslverr while running op %0d width %0d", op, width);
			error_count++;
		end
		result = {hi, lo};
	endtask

	// lane by lane model of the alu rules
	function automatic snow64_alu_pkg::data_t expect_result(input logic [3:0] op,
		input logic [1:0] width, input snow64_alu_pkg::data_t a,
		input snow64_alu_pkg::data_t b);
		int w;
		snow64_alu_pkg::data_t mask;
		snow64_alu_pkg::data_t sign_bit;
		snow64_alu_pkg::data_t la;
		snow64_alu_pkg::data_t lb;
		snow64_alu_pkg::data_t fill;
		snow64_alu_pkg::data_t lane_res;
		snow64_alu_pkg::data_t res;
		w = 8 << width;
		mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
		sign_bit = 64'd1 << (w - 1);
		res = '0;
		for (int l = 0; l < 64 / w; l++)
		begin
			la = (a >> (l * w)) & mask;
			lb = (b >> (l * w)) & mask;
			fill = ((la & sign_bit) != 0) ? mask : '0;
			case (op)
				op_add: lane_res = la + lb;
				op_sub: lane_res = la - lb;
				op_sltu: lane_res = (la < lb) ? 64'd1 : 64'd0;
				// flipped sign bits make the signed order unsigned
				op_slts: lane_res = ((la ^ sign_bit) < (lb ^ sign_bit)) ? 64'd1 : 64'd0;
				op_and: lane_res = la & lb;
				op_or: lane_res = la | lb;
				op_xor: lane_res = la ^ lb;
				op_lsl: lane_res = (lb >= w) ? '0 : (la << lb);
				op_lsr: lane_res = (lb >= w) ? '0 : (la >> lb);
				default: lane_res = (lb >= w) ? fill : ((la >> lb) | (fill & ~(mask >> lb)));
			endcase
			res = res | ((lane_res & mask) << (l * w));
		end
		return res;
	endfunction

	// shift amounts below twice the lane width
	function automatic snow64_alu_pkg::data_t amount_mask(input logic [1:0] width);
		int w;
		snow64_alu_pkg::data_t m;
		w = 8 << width;
		m = '0;
		for (int l = 0; l < 64 / w; l++)
		begin
			m = m | (64'(2 * w - 1) << (l * w));
		end
		return m;
	endfunction

	task automatic add_vector(input logic [3:0] op, input logic [1:0] width,
		input snow64_alu_pkg::data_t a, input snow64_alu_pkg::data_t b,
		input snow64_alu_pkg::data_t expected);
		vector_t v;
		v.op = op;
		v.width = width;
		v.a = a;
		v.b = b;
		v.expected = expected;
		vectors.push_back(v);
	endtask

	task automatic fill_table();
		// lane wrap leaves neighbor lanes untouched
		add_vector(op_add, 0, 64'h1122_3344_5566_77ff, 64'h0000_0000_0000_0001,
			64'h1122_3344_5566_7700);
		add_vector(op_add, 1, 64'h0001_0002_0003_ffff, 64'h0000_0000_0000_0001,
			64'h0001_0002_0003_0000);
		add_vector(op_add, 2, 64'h0000_0005_ffff_ffff, 64'h0000_0001_0000_0001,
			64'h0000_0006_0000_0000);
		add_vector(op_add, 3, 64'h0000_0000_ffff_ffff, 64'h0000_0000_0000_0001,
			64'h0000_0001_0000_0000);
		add_vector(op_sub, 0, 64'h1020_3040_5060_7000, 64'h0101_0101_0101_0101,
			64'h0f1f_2f3f_4f5f_6fff);
		add_vector(op_sub, 1, 64'h0000_0000_0000_0000, 64'h0000_0000_0000_0001,
			64'h0000_0000_0000_ffff);
		add_vector(op_sub, 2, 64'h0000_0001_0000_0000, 64'h0000_0000_0000_0001,
			64'h0000_0001_ffff_ffff);
		add_vector(op_sub, 3, 64'h0000_0001_0000_0000, 64'h0000_0000_0000_0001,
			64'h0000_0000_ffff_ffff);
		// signed and unsigned disagree on the lanes with the top bit set
		add_vector(op_sltu, 0, 64'h0000_0000_0000_8001, 64'h0000_0000_0000_0180,
			64'h0000_0000_0000_0001);
		add_vector(op_slts, 0, 64'h0000_0000_0000_8001, 64'h0000_0000_0000_0180,
			64'h0000_0000_0000_0100);
		add_vector(op_slts, 1, 64'h0000_0000_ffff_0001, 64'h0000_0000_0001_ffff,
			64'h0000_0000_0001_0000);
		add_vector(op_sltu, 2, 64'h8000_0000_0000_0005, 64'h0000_0001_0000_0007,
			64'h0000_0000_0000_0001);
		add_vector(op_slts, 2, 64'h8000_0000_0000_0005, 64'h0000_0001_0000_0007,
			64'h0000_0001_0000_0001);
		add_vector(op_sltu, 3, 64'hffff_ffff_ffff_ffff, 64'h0000_0000_0000_0001,
			64'h0000_0000_0000_0000);
		add_vector(op_slts, 3, 64'hffff_ffff_ffff_ffff, 64'h0000_0000_0000_0001,
			64'h0000_0000_0000_0001);
		add_vector(op_and, 0, 64'hf0f0_f0f0_ff00_ff00, 64'h0ff0_0ff0_f0f0_f0f0,
			64'h00f0_00f0_f000_f000);
		add_vector(op_or, 3, 64'hf0f0_f0f0_ff00_ff00, 64'h0ff0_0ff0_f0f0_f0f0,
			64'hfff0_fff0_fff0_fff0);
		add_vector(op_xor, 1, 64'hf0f0_f0f0_ff00_ff00, 64'h0ff0_0ff0_f0f0_f0f0,
			64'hff00_ff00_0ff0_0ff0);
		// per-lane amounts with the top three lanes over range
		add_vector(op_lsl, 0, 64'h0101_0101_0101_0101, 64'hff09_0807_0302_0100,
			64'h0000_0080_0804_0201);
		add_vector(op_lsr, 0, 64'h8080_8080_8080_8080, 64'hff09_0807_0302_0100,
			64'h0000_0001_1020_4080);
		add_vector(op_asr, 0, 64'h8080_8080_8080_8080, 64'hff09_0807_0302_0100,
			64'hffff_ffff_f0e0_c080);
		add_vector(op_asr, 1, 64'h8000_4000_8000_8000, 64'h0001_0001_0010_0004,
			64'hc000_2000_ffff_f800);
		add_vector(op_lsr, 1, 64'hffff_ffff_ffff_ffff, 64'h000f_0008_0001_0000,
			64'h0001_00ff_7fff_ffff);
		// high amount bits set with small low bits
		add_vector(op_lsl, 2, 64'h0000_0001_0000_0001, 64'h8000_0001_0000_001f,
			64'h0000_0000_8000_0000);
		add_vector(op_lsr, 3, 64'h8000_0000_0000_0000, 64'h0000_0000_0000_003f,
			64'h0000_0000_0000_0001);
		add_vector(op_asr, 3, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0001,
			64'hffff_ffff_ffff_ffff);
	endtask

	initial
	begin
		snow64_alu_pkg::data_t result;
		snow64_alu_pkg::data_t last;
		snow64_alu_pkg::data_t a;
		snow64_alu_pkg::data_t b;
		snow64_alu_pkg::apb_data_t lo;
		snow64_alu_pkg::apb_data_t hi;
		logic [3:0] op;
		logic [1:0] width;

		void'($urandom(32'hdb0c_37ef));
		apb_req = '0;
		arst_n = 1'b0;
		error_count = 0;
		fill_table();
		cycle_limit = (vectors.size() + NUM_RANDOM) * 20 + 500;
		repeat (10) @(negedge clk);
		arst_n = 1'b1;

		// done clear out of reset
		read_register(snow64_alu_pkg::addr_status, lo);
		check_value("status", 64'd0, {32'd0, lo});

		foreach (vectors[i])
		begin
			run_command(vectors[i].op, vectors[i].width, vectors[i].a, vectors[i].b, result);
			check_value("result", vectors[i].expected, result);
		end
		read_register(snow64_alu_pkg::addr_status, lo);
		check_value("status", 64'd1, {32'd0, lo});

		// read-only targets, holes in the map, bad op
		last = result;
		expect_slverr(1'b1, snow64_alu_pkg::addr_res_lo, 32'h1234_5678);
		expect_slverr(1'b1, snow64_alu_pkg::addr_res_hi, 32'h1234_5678);
		expect_slverr(1'b1, snow64_alu_pkg::addr_status, 32'h0000_0000);
		expect_slverr(1'b1, 5'h02, 32'hdead_beef);
		expect_slverr(1'b0, 5'h13, 32'h0000_0000);
		expect_slverr(1'b1, snow64_alu_pkg::addr_ctrl, 32'h0000_000a);
		read_register(snow64_alu_pkg::addr_res_lo, lo);
		read_register(snow64_alu_pkg::addr_res_hi, hi);
		check_value("result", last, {hi, lo});
		read_register(snow64_alu_pkg::addr_status, lo);
		check_value("status", 64'd1, {32'd0, lo});

		repeat (NUM_RANDOM)
		begin
			op = 4'($urandom_range(9, 0));
			width = 2'($urandom_range(3, 0));
			a = {$urandom, $urandom};
			b = {$urandom, $urandom};
			if (op >= op_lsl && $urandom_range(3, 0) != 0)
			begin
				b = b & amount_mask(width);
			end
			run_command(op, width, a, b, result);
			check_value("result", expect_result(op, width, a, b), result);
		end

		$display("run complete, %0d errors", error_count);
		if (error_count == 0)
		begin
			$display("Finished with no errors");
		end
		else
		begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
rtl/snow64_alu_pkg.sv
rtl/snow64_lane_shifter.sv
rtl/snow64_lane_adder.sv
rtl/snow64_alu_exec.sv
rtl/snow64_alu_apb_regs.sv
rtl/snow64_alu_top.sv
sim/snow64_alu_properties.sv
sim/snow64_alu_tb.sv

// ==== Bender.yml ====
package:
  name: snow64_alu

sources:
  - rtl/snow64_alu_pkg.sv
  - rtl/snow64_lane_shifter.sv
  - rtl/snow64_lane_adder.sv
  - rtl/snow64_alu_exec.sv
  - rtl/snow64_alu_apb_regs.sv
  - rtl/snow64_alu_top.sv
  - target: simulation
    files:
      - sim/snow64_alu_properties.sv
      - sim/snow64_alu_tb.sv
